/* filelist.f */
+incdir+include
rtl/tx_dma_pkg.sv
rtl/rd_req_issuer.sv
rtl/tag_table.sv
rtl/cpl_writer.sv
rtl/tx_cpl_to_bram.sv
dv/tb_tx_cpl_to_bram.sv

/* include/tb_host_model.svh */
`ifndef TB_HOST_MODEL_SVH
`define TB_HOST_MODEL_SVH

//////////////////////////////
// stimulus and checking
//////////////////////////////
function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);     // galois form, taps 16 14 13 11
endfunction

task automatic next_dword(output logic [31:0] d);
    for (int i = 0; i < 32; i++) begin
        d[i]       = lfsr_state[0];                     // one step per bit
        lfsr_state = lfsr_step(lfsr_state);
    end
endtask

function automatic logic [31:0] reverse_bytes(input logic [31:0] d);
    logic [31:0] r;
    for (int b = 0; b < 4; b++) begin
        r[8*b +: 8] = d[8*(3-b) +: 8];
    end
    return r;
endfunction

task automatic check_value(input string what, input logic [63:0] actual,
                           input logic [63:0] expected);
    if (actual !== expected) begin
        $display("mismatch at %0t ns: %s is %0h, expected %0h", $time, what, actual, expected);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at the first error");
    end
endtask

task automatic report_failure(input string msg);
    $display("error at %0t ns: %s", $time, msg);
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at the first error");
endtask

//////////////////////////////
// host and completer model
//////////////////////////////
task automatic offer_region(input logic [2:0] cfg, input host_addr_t addr,
                            input region_len_t qw);
    @(posedge trn_clk);
    cfg_max_rd_req_size <= cfg;
    repeat (3) @(posedge trn_clk);                      // config goes through two registers
    huge_page_addr   <= addr;
    huge_page_qwords <= qw;
    huge_page_status <= 1'b1;
endtask

task automatic release_region();
    @(posedge trn_clk);
    huge_page_status <= 1'b0;
    repeat (3) @(posedge trn_clk);
endtask

task automatic take_request(output tag_t tag, output rd_size_t size,
                            output host_addr_t addr, output buf_addr_t base);
    @(negedge trn_clk);
    while (!read_chunk) begin
        @(negedge trn_clk);
    end
    size = qwords_to_rd;
    addr = huge_page_addr_read_from;
    tag  = tag_t'(tag_seq);                             // in-order retire keeps this tag free
    base = wr_ptr_model[BUF_AW-1:0];
    tag_seq++;
    wr_ptr_model = wr_ptr_model + buf_ptr_t'(size);
    @(posedge trn_clk);
    tlp_tag        <= tag;
    read_chunk_ack <= 1'b1;
    @(posedge trn_clk);
    read_chunk_ack <= 1'b0;
endtask

task automatic drive_beat(input qword_t data, input logic sof_n, input logic eof_n);
    @(posedge trn_clk);
    trn_rd         <= data;
    trn_rsof_n     <= sof_n;
    trn_reof_n     <= eof_n;
    trn_rsrc_rdy_n <= 1'b0;
endtask

task automatic send_cpl(input tag_t tag, input buf_addr_t base, input rd_size_t nqw,
                        input logic [6:0] fmt, input logic [2:0] status, input logic expect_wr);
    logic [31:0] dw [258];
    qword_t      hdr;
    for (int i = 0; i < 2 * nqw; i++) begin
        next_dword(dw[i]);
    end
    dw[2 * nqw] = 32'h0;                                // unused low half of the last beat
    if (expect_wr) begin
        for (int k = 0; k < nqw; k++) begin
            exp_addr_q.push_back(buf_addr_t'(base + k));
            exp_data_q.push_back({reverse_bytes(dw[2*k+1]), reverse_bytes(dw[2*k])});
        end
    end
    hdr          = '0;
    hdr[62:56]   = fmt;
    hdr[41:32]   = 10'(2 * nqw);
    hdr[15:13]   = status;
    drive_beat(hdr, 1'b0, 1'b1);
    hdr          = '0;
    hdr[41:40]   = tag;
    hdr[31:0]    = dw[0];
    drive_beat(hdr, 1'b1, 1'b1);
    for (int k = 0; k < nqw; k++) begin
        drive_beat({dw[2*k+1], dw[2*k+2]}, 1'b1, (k != nqw - 1));
    end
    @(posedge trn_clk);
    trn_rsrc_rdy_n <= 1'b1;
    trn_rsof_n     <= 1'b1;
    trn_reof_n     <= 1'b1;
endtask

task automatic wait_writes();
    @(negedge trn_clk);
    while (exp_addr_q.size() != 0) begin
        @(negedge trn_clk);
    end
endtask

task automatic wait_commit(input buf_ptr_t target);
    @(negedge trn_clk);
    while (commited_wr_addr !== target) begin
        @(negedge trn_clk);
    end
endtask

task automatic consume_ring();
    @(posedge trn_clk);
    commited_rd_addr <= commited_wr_addr;               // consumer drains all committed data
endtask

task automatic serve_request(input rd_size_t exp_size, input host_addr_t exp_addr);
    tag_t       tag;
    rd_size_t   size;
    host_addr_t addr;
    buf_addr_t  base;
    take_request(tag, size, addr, base);
    check_value("qwords_to_rd", size, exp_size);
    check_value("huge_page_addr_read_from", addr, exp_addr);
    send_cpl(tag, base, size, CPL_FMT_TYPE, CPL_STATUS_SC, 1'b1);
    wait_writes();
    wait_commit(wr_ptr_model);
    consume_ring();
endtask

//////////////////////////////
// directed tests
//////////////////////////////
task automatic reset_outputs();
    @(negedge trn_clk);
    check_value("read_chunk after reset", read_chunk, 0);
    check_value("huge_page_free after reset", huge_page_free, 0);
    check_value("wr_en after reset", wr_en, 0);
    check_value("commited_wr_addr after reset", commited_wr_addr, 0);
endtask

task automatic request_splitting();
    region_len_t left;
    rd_size_t    limit;
    rd_size_t    exp_size;
    host_addr_t  exp_addr;
    int          frees;
    for (int s = 0; s < 4; s++) begin
        limit    = rd_size_t'(16 << s);
        left     = 200;
        exp_addr = 64'h0000_0040_0000_0000 + host_addr_t'(s) * 64'h1_0000;
        frees    = free_count;
        offer_region(3'(s), exp_addr, left);
        while (left != 0) begin
            exp_size = (left < region_len_t'(limit)) ? rd_size_t'(left) : limit;
            serve_request(exp_size, exp_addr);
            left     = left - region_len_t'(exp_size);
            exp_addr = exp_addr + 8 * exp_size;
        end
        repeat (4) @(negedge trn_clk);
        check_value("huge_page_free pulses", free_count - frees, 1);
        release_region();
    end
endtask

task automatic data_placement();
    tag_t       t0, t1;
    rd_size_t   s0, s1;
    host_addr_t a0, a1;
    buf_addr_t  b0, b1;
    offer_region(3'd2, 64'h0000_0050_0000_1000, 100);
    take_request(t0, s0, a0, b0);
    take_request(t1, s1, a1, b1);                       // both outstanding at once
    check_value("first request size", s0, 64);
    check_value("first request address", a0, 64'h0000_0050_0000_1000);
    check_value("second request size", s1, 36);
    check_value("second request address", a1, 64'h0000_0050_0000_1200);
    send_cpl(t0, b0, s0, CPL_FMT_TYPE, CPL_STATUS_SC, 1'b1);
    send_cpl(t1, b1, s1, CPL_FMT_TYPE, CPL_STATUS_SC, 1'b1);
    wait_writes();
    wait_commit(wr_ptr_model);
    consume_ring();
    release_region();
endtask

task automatic in_order_commit();
    tag_t       tg [4];
    rd_size_t   sz [4];
    host_addr_t ad [4];
    buf_addr_t  bs [4];
    buf_ptr_t   start;
    start = wr_ptr_model;
    offer_region(3'd0, 64'h0000_0070_0000_0000, 80);
    for (int i = 0; i < 4; i++) begin
        take_request(tg[i], sz[i], ad[i], bs[i]);
        check_value("qwords_to_rd", sz[i], 16);
        check_value("huge_page_addr_read_from", ad[i], 64'h0000_0070_0000_0000 + 128 * i);
    end
    // fifth request waits for a free tag
    repeat (100) begin
        @(negedge trn_clk);
        check_value("read_chunk with four tags out", read_chunk, 0);
    end
    for (int i = 3; i > 0; i--) begin
        send_cpl(tg[i], bs[i], sz[i], CPL_FMT_TYPE, CPL_STATUS_SC, 1'b1);
        wait_writes();
        repeat (4) @(negedge trn_clk);
        check_value("commited_wr_addr before the oldest", commited_wr_addr, start);
    end
    send_cpl(tg[0], bs[0], sz[0], CPL_FMT_TYPE, CPL_STATUS_SC, 1'b1);
    wait_writes();
    wait_commit(buf_ptr_t'(start + 10'd64));
    serve_request(16, 64'h0000_0070_0000_0200);
    release_region();
endtask

task automatic ring_backpressure();
    tag_t       tag;
    rd_size_t   size;
    host_addr_t addr;
    host_addr_t exp_addr;
    buf_addr_t  base;
    exp_addr = 64'h0000_0060_0000_0000;
    offer_region(3'd3, exp_addr, 1024);
    for (int i = 0; i < 4; i++) begin
        take_request(tag, size, addr, base);
        check_value("qwords_to_rd", size, 128);
        check_value("huge_page_addr_read_from", addr, exp_addr);
        send_cpl(tag, base, size, CPL_FMT_TYPE, CPL_STATUS_SC, 1'b1);
        wait_writes();
        exp_addr = exp_addr + 1024;
    end
    wait_commit(wr_ptr_model);
    repeat (100) begin
        @(negedge trn_clk);
        check_value("read_chunk with a full ring", read_chunk, 0);
    end
    consume_ring();                                     // frees the whole ring
    for (int i = 0; i < 4; i++) begin
        serve_request(128, exp_addr);
        exp_addr = exp_addr + 1024;
    end
    release_region();
endtask

task automatic tlp_filtering();
    int writes;
    writes = write_count;
    send_cpl(2'd0, 9'd0, 4, CPL_FMT_TYPE, 3'b001, 1'b0);    // unsupported request
    send_cpl(2'd0, 9'd0, 4, 7'h40, CPL_STATUS_SC, 1'b0);    // memory write
    repeat (10) @(negedge trn_clk);
    check_value("writes from filtered TLPs", write_count - writes, 0);
endtask

`endif

/* dv/tb_tx_cpl_to_bram.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_tx_cpl_to_bram
    import tx_dma_pkg::*;
();

    // about 4000 cycles of traffic, five times that as margin
    localparam int CYCLE_LIMIT = 20000;

    logic        trn_clk;
    logic        reset;
    qword_t      trn_rd;
    logic        trn_rsof_n;
    logic        trn_reof_n;
    logic        trn_rsrc_rdy_n;
    logic        trn_rdst_rdy_n;
    logic [2:0]  cfg_max_rd_req_size;
    host_addr_t  huge_page_addr;
    region_len_t huge_page_qwords;
    logic        huge_page_status;
    logic        huge_page_free;
    logic        read_chunk;
    host_addr_t  huge_page_addr_read_from;
    rd_size_t    qwords_to_rd;
    tag_t        tlp_tag;
    logic        read_chunk_ack;
    buf_addr_t   wr_addr;
    qword_t      wr_data;
    logic        wr_en;
    buf_ptr_t    commited_rd_addr;
    buf_ptr_t    commited_wr_addr;

    logic [15:0] lfsr_state = 16'd63;
    int          tag_seq = 0;
    buf_ptr_t    wr_ptr_model = '0;                     // expected issuer write pointer
    int          free_count = 0;
    int          write_count = 0;
    int          cycle_count = 0;
    buf_addr_t   exp_addr_q [$];
    qword_t      exp_data_q [$];

    `include "tb_host_model.svh"

    tx_cpl_to_bram u_dut (
        .trn_clk                  (trn_clk),
        .reset                    (reset),
        .trn_rd                   (trn_rd),
        .trn_rsof_n               (trn_rsof_n),
        .trn_reof_n               (trn_reof_n),
        .trn_rsrc_rdy_n           (trn_rsrc_rdy_n),
        .trn_rdst_rdy_n           (trn_rdst_rdy_n),
        .cfg_max_rd_req_size      (cfg_max_rd_req_size),
        .huge_page_addr           (huge_page_addr),
        .huge_page_qwords         (huge_page_qwords),
        .huge_page_status         (huge_page_status),
        .huge_page_free           (huge_page_free),
        .read_chunk               (read_chunk),
        .huge_page_addr_read_from (huge_page_addr_read_from),
        .qwords_to_rd             (qwords_to_rd),
        .tlp_tag                  (tlp_tag),
        .read_chunk_ack           (read_chunk_ack),
        .wr_addr                  (wr_addr),
        .wr_data                  (wr_data),
        .wr_en                    (wr_en),
        .commited_rd_addr         (commited_rd_addr),
        .commited_wr_addr         (commited_wr_addr)
    );

    initial begin
        trn_clk = 1'b0;
        forever #50 trn_clk = ~trn_clk;
    end

    //////////////////////////////
    // monitors
    //////////////////////////////
    always @(negedge trn_clk) begin : ring_monitor
        buf_addr_t a;
        qword_t    d;
        if (huge_page_free === 1'b1) begin
            free_count++;
        end
        if (wr_en === 1'b1) begin
            write_count++;
            if (exp_addr_q.size() == 0) begin
                report_failure("the DUT wrote to the ring when no qword was expected");
            end else begin
                a = exp_addr_q.pop_front();
                d = exp_data_q.pop_front();
                check_value("wr_addr", wr_addr, a);
                check_value("wr_data", wr_data, d);
            end
        end
    end

    always @(posedge trn_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Simulation finished: FAIL");
            $fatal(1, "timeout");
        end
    end

    //////////////////////////////
    // test sequence
    //////////////////////////////
    initial begin
        reset               = 1'b1;
        trn_rd              = '0;
        trn_rsof_n          = 1'b1;
        trn_reof_n          = 1'b1;
        trn_rsrc_rdy_n      = 1'b1;
        trn_rdst_rdy_n      = 1'b0;                     // sink always ready
        cfg_max_rd_req_size = 3'd0;
        huge_page_addr      = '0;
        huge_page_qwords    = '0;
        huge_page_status    = 1'b0;
        tlp_tag             = '0;
        read_chunk_ack      = 1'b0;
        commited_rd_addr    = '0;
        repeat (16) @(posedge trn_clk);
        reset <= 1'b0;

        reset_outputs();
        request_splitting();
        data_placement();
        in_order_commit();
        ring_backpressure();
        tlp_filtering();

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* rtl/tx_cpl_to_bram.sv */
`timescale 1ns/1ps
`default_nettype none

module tx_cpl_to_bram
    import tx_dma_pkg::*;
(
    input  logic        trn_clk,
    input  logic        reset,

    // completion stream from the endpoint
    input  qword_t      trn_rd,
    input  logic        trn_rsof_n,
    input  logic        trn_reof_n,
    input  logic        trn_rsrc_rdy_n,
    input  logic        trn_rdst_rdy_n,
    input  logic [2:0]  cfg_max_rd_req_size,

    // host region
    input  host_addr_t  huge_page_addr,
    input  region_len_t huge_page_qwords,
    input  logic        huge_page_status,
    output logic        huge_page_free,

    // read requests
    output logic        read_chunk,
    output host_addr_t  huge_page_addr_read_from,
    output rd_size_t    qwords_to_rd,
    input  tag_t        tlp_tag,
    input  logic        read_chunk_ack,

    // ring buffer port
    output buf_addr_t   wr_addr,
    output qword_t      wr_data,
    output logic        wr_en,

    input  buf_ptr_t    commited_rd_addr,
    output buf_ptr_t    commited_wr_addr
);

    logic      req_accept;
    tag_t      req_tag;
    buf_addr_t req_base;
    rd_size_t  req_size;
    logic      tags_full;

    tag_t      lookup_tag;
    buf_addr_t lookup_addr;
    logic      cpl_done;
    tag_t      cpl_tag;
    rd_size_t  cpl_qwords;
    buf_addr_t cpl_next_addr;

    //////////////////////////////
    // request side
    //////////////////////////////
    rd_req_issuer u_issuer (
        .trn_clk                  (trn_clk),
        .reset                    (reset),
        .huge_page_addr           (huge_page_addr),
        .huge_page_qwords         (huge_page_qwords),
        .huge_page_status         (huge_page_status),
        .cfg_max_rd_req_size      (cfg_max_rd_req_size),
        .commited_rd_addr         (commited_rd_addr),
        .tags_full                (tags_full),
        .tlp_tag                  (tlp_tag),
        .read_chunk_ack           (read_chunk_ack),
        .read_chunk               (read_chunk),
        .huge_page_addr_read_from (huge_page_addr_read_from),
        .qwords_to_rd             (qwords_to_rd),
        .huge_page_free           (huge_page_free),
        .req_accept               (req_accept),
        .req_tag                  (req_tag),
        .req_base                 (req_base),
        .req_size                 (req_size)
    );

    tag_table u_tags (
        .trn_clk          (trn_clk),
        .reset            (reset),
        .req_accept       (req_accept),
        .req_tag          (req_tag),
        .req_base         (req_base),
        .req_size         (req_size),
        .lookup_tag       (lookup_tag),
        .lookup_addr      (lookup_addr),
        .cpl_done         (cpl_done),
        .cpl_tag          (cpl_tag),
        .cpl_qwords       (cpl_qwords),
        .cpl_next_addr    (cpl_next_addr),
        .tags_full        (tags_full),
        .commited_wr_addr (commited_wr_addr)
    );

    //////////////////////////////
    // completion side
    //////////////////////////////
    cpl_writer u_writer (
        .trn_clk        (trn_clk),
        .reset          (reset),
        .trn_rd         (trn_rd),
        .trn_rsof_n     (trn_rsof_n),
        .trn_reof_n     (trn_reof_n),
        .trn_rsrc_rdy_n (trn_rsrc_rdy_n),
        .trn_rdst_rdy_n (trn_rdst_rdy_n),
        .lookup_tag     (lookup_tag),
        .lookup_addr    (lookup_addr),
        .wr_addr        (wr_addr),
        .wr_data        (wr_data),
        .wr_en          (wr_en),
        .cpl_done       (cpl_done),
        .cpl_tag        (cpl_tag),
        .cpl_qwords     (cpl_qwords),
        .cpl_next_addr  (cpl_next_addr)
    );

endmodule

`default_nettype wire

/* rtl/cpl_writer.sv */
`timescale 1ns/1ps
`default_nettype none

module cpl_writer
    import tx_dma_pkg::*;
(
    input  logic      trn_clk,
    input  logic      reset,

    input  qword_t    trn_rd,
    input  logic      trn_rsof_n,
    input  logic      trn_reof_n,
    input  logic      trn_rsrc_rdy_n,
    input  logic      trn_rdst_rdy_n,

    output tag_t      lookup_tag,
    input  buf_addr_t lookup_addr,

    output buf_addr_t wr_addr,
    output qword_t    wr_data,
    output logic      wr_en,

    output logic      cpl_done,
    output tag_t      cpl_tag,
    output rd_size_t  cpl_qwords,
    output buf_addr_t cpl_next_addr
);

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_HDR2,
        WR_DATA
    } wr_state_t;

    wr_state_t state;

    logic        beat_ok;
    logic        hdr_ok;
    rd_size_t    tlp_qwords;                            // from the dword length
    tag_t        cur_tag;
    buf_addr_t   wr_ptr;
    logic [31:0] dw_lo;                                 // even dword waiting for its pair

    function automatic logic [31:0] bswap32(input logic [31:0] d);
        return {d[7:0], d[15:8], d[23:16], d[31:24]};
    endfunction

    assign beat_ok = !trn_rsrc_rdy_n && !trn_rdst_rdy_n;
    assign hdr_ok  = (trn_rd[62:56] == CPL_FMT_TYPE) && (trn_rd[15:13] == CPL_STATUS_SC);

    // tag sits in header dword 2, only looked at in WR_HDR2
    assign lookup_tag = trn_rd[41:40];

    //////////////////////////////
    // completion parser
    //////////////////////////////
    always_ff @(posedge trn_clk) begin
        if (reset) begin
            state    <= WR_IDLE;
            wr_en    <= 1'b0;
            cpl_done <= 1'b0;
        end else begin
            wr_en    <= 1'b0;
            cpl_done <= 1'b0;

            case (state)
                WR_IDLE: begin
                    tlp_qwords <= trn_rd[41:33];            // even dword count
                    if (beat_ok && !trn_rsof_n && hdr_ok) begin
                        state <= WR_HDR2;
                    end
                end

                WR_HDR2: begin
                    cur_tag <= trn_rd[41:40];
                    wr_ptr  <= lookup_addr;
                    dw_lo   <= trn_rd[31:0];                // data dword 0
                    if (beat_ok) begin
                        state <= WR_DATA;
                    end
                end

                WR_DATA: begin
                    if (beat_ok) begin
                        wr_en   <= 1'b1;
                        wr_addr <= wr_ptr;
                        wr_data <= {bswap32(trn_rd[63:32]), bswap32(dw_lo)};
                        wr_ptr  <= wr_ptr + 1'b1;           // wraps at 512
                        dw_lo   <= trn_rd[31:0];
                        if (!trn_reof_n) begin
                            cpl_done      <= 1'b1;
                            cpl_tag       <= cur_tag;
                            cpl_qwords    <= tlp_qwords;
                            cpl_next_addr <= wr_ptr + 1'b1;
                            state         <= WR_IDLE;
                        end
                    end
                end

                default: begin
                    state <= WR_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* rtl/tag_table.sv */
`timescale 1ns/1ps
`default_nettype none

module tag_table
    import tx_dma_pkg::*;
(
    input  logic      trn_clk,
    input  logic      reset,

    input  logic      req_accept,
    input  tag_t      req_tag,
    input  buf_addr_t req_base,
    input  rd_size_t  req_size,

    input  tag_t      lookup_tag,
    output buf_addr_t lookup_addr,

    input  logic      cpl_done,
    input  tag_t      cpl_tag,
    input  rd_size_t  cpl_qwords,
    input  buf_addr_t cpl_next_addr,

    output logic      tags_full,
    output buf_ptr_t  commited_wr_addr
);

    typedef enum logic {
        CM_CHECK,
        CM_RETIRE
    } commit_state_t;

    commit_state_t state;

    // per tag records
    buf_addr_t rec_addr [N_TAGS];                       // next ring address
    rd_size_t  rec_size [N_TAGS];
    rd_size_t  rec_rcvd [N_TAGS];
    logic      rec_done [N_TAGS];

    // issue order queue
    tag_t                order_q [N_TAGS];
    logic [$bits(tag_t):0] sent_cnt;
    logic [$bits(tag_t):0] cmpl_cnt;
    logic [$bits(tag_t):0] in_flight;

    tag_t     head_tag;
    logic     head_hit;
    logic     head_ready;
    tag_t     retire_tag;
    rd_size_t retire_size;

    assign lookup_addr = rec_addr[lookup_tag];

    assign in_flight = sent_cnt - cmpl_cnt;
    assign tags_full = (in_flight == N_TAGS);

    // oldest request, done either already or by the completion ending now
    assign head_tag   = order_q[tag_t'(cmpl_cnt)];
    assign head_hit   = cpl_done && (cpl_tag == head_tag) &&
                        (rec_rcvd[head_tag] + cpl_qwords == rec_size[head_tag]);
    assign head_ready = (in_flight != '0) && (rec_done[head_tag] || head_hit);

    //////////////////////////////
    // record storage
    //////////////////////////////
    always_ff @(posedge trn_clk) begin
        if (req_accept) begin
            rec_addr[req_tag]           <= req_base;
            rec_size[req_tag]           <= req_size;
            rec_rcvd[req_tag]           <= '0;
            order_q[tag_t'(sent_cnt)]   <= req_tag;
        end
        if (cpl_done) begin
            rec_addr[cpl_tag] <= cpl_next_addr;
            rec_rcvd[cpl_tag] <= rec_rcvd[cpl_tag] + cpl_qwords;
        end
    end

    //////////////////////////////
    // in-order commit
    //////////////////////////////
    always_ff @(posedge trn_clk) begin
        if (reset) begin
            state            <= CM_CHECK;
            sent_cnt         <= '0;
            cmpl_cnt         <= '0;
            commited_wr_addr <= '0;
            for (int i = 0; i < N_TAGS; i++) begin
                rec_done[i] <= 1'b0;
            end
        end else begin
            if (req_accept) begin
                sent_cnt          <= sent_cnt + 1'b1;
                rec_done[req_tag] <= 1'b0;
            end
            if (cpl_done && (rec_rcvd[cpl_tag] + cpl_qwords == rec_size[cpl_tag])) begin
                rec_done[cpl_tag] <= 1'b1;                  // all qwords in
            end

            case (state)
                CM_CHECK: begin
                    retire_tag  <= head_tag;
                    retire_size <= rec_size[head_tag];
                    if (head_ready) begin
                        state <= CM_RETIRE;
                    end
                end

                CM_RETIRE: begin
                    commited_wr_addr     <= commited_wr_addr + buf_ptr_t'(retire_size);
                    cmpl_cnt             <= cmpl_cnt + 1'b1;
                    rec_done[retire_tag] <= 1'b0;
                    state                <= CM_CHECK;
                end

                default: begin
                    state <= CM_CHECK;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* rtl/rd_req_issuer.sv */
`timescale 1ns/1ps
`default_nettype none

module rd_req_issuer
    import tx_dma_pkg::*;
(
    input  logic        trn_clk,
    input  logic        reset,

    input  host_addr_t  huge_page_addr,
    input  region_len_t huge_page_qwords,
    input  logic        huge_page_status,
    input  logic [2:0]  cfg_max_rd_req_size,
    input  buf_ptr_t    commited_rd_addr,
    input  logic        tags_full,
    input  tag_t        tlp_tag,
    input  logic        read_chunk_ack,

    output logic        read_chunk,
    output host_addr_t  huge_page_addr_read_from,
    output rd_size_t    qwords_to_rd,
    output logic        huge_page_free,

    output logic        req_accept,
    output tag_t        req_tag,
    output buf_addr_t   req_base,
    output rd_size_t    req_size
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_SIZE,
        ST_SETTLE,
        ST_ISSUE,
        ST_ACK,
        ST_DONE
    } issue_state_t;

    issue_state_t state;

    logic [2:0]   cfg_reg;
    rd_size_t     max_qw;
    region_len_t  remaining;                            // qwords left in region
    buf_ptr_t     next_wr_ptr;
    logic [9:0]   used_qw;
    logic [9:0]   free_space;
    logic         fits;

    //////////////////////////////
    // request size limit
    //////////////////////////////
    always_ff @(posedge trn_clk) begin
        cfg_reg <= cfg_max_rd_req_size;                 // quasi-static config
        case (cfg_reg)
            3'd0:    max_qw <= MAX_QW_128B;
            3'd1:    max_qw <= MAX_QW_256B;
            3'd2:    max_qw <= MAX_QW_512B;
            default: max_qw <= MAX_QW_1KB;
        endcase
    end

    // ring occupancy seen from the write side
    assign used_qw    = next_wr_ptr - commited_rd_addr;
    assign free_space = 10'd512 - used_qw;

    always_ff @(posedge trn_clk) begin
        fits <= (free_space >= {1'b0, qwords_to_rd});
    end

    // record for the tag table, taken in the ack cycle
    assign req_accept = read_chunk & read_chunk_ack;
    assign req_tag    = tlp_tag;
    assign req_base   = next_wr_ptr[BUF_AW-1:0];
    assign req_size   = qwords_to_rd;

    //////////////////////////////
    // request FSM
    //////////////////////////////
    always_ff @(posedge trn_clk) begin
        if (reset) begin
            state          <= ST_IDLE;
            read_chunk     <= 1'b0;
            huge_page_free <= 1'b0;
            next_wr_ptr    <= '0;
        end else begin
            huge_page_free <= 1'b0;

            case (state)
                ST_IDLE: begin
                    huge_page_addr_read_from <= huge_page_addr;
                    remaining                <= huge_page_qwords;
                    if (huge_page_status) begin
                        state <= ST_SIZE;
                    end
                end

                ST_SIZE: begin
                    if (remaining == '0) begin
                        huge_page_free <= 1'b1;             // region fully requested
                        state          <= ST_DONE;
                    end else begin
                        if (remaining < region_len_t'(max_qw)) begin
                            qwords_to_rd <= rd_size_t'(remaining);
                        end else begin
                            qwords_to_rd <= max_qw;
                        end
                        state <= ST_SETTLE;
                    end
                end

                ST_SETTLE: begin
                    state <= ST_ISSUE;                      // let fits catch up
                end

                ST_ISSUE: begin
                    if (fits && !tags_full) begin
                        read_chunk <= 1'b1;
                        state      <= ST_ACK;
                    end
                end

                ST_ACK: begin
                    if (read_chunk_ack) begin
                        read_chunk  <= 1'b0;
                        next_wr_ptr <= next_wr_ptr + buf_ptr_t'(qwords_to_rd);
                        remaining   <= remaining - region_len_t'(qwords_to_rd);
                        huge_page_addr_read_from <= huge_page_addr_read_from +
                                                    host_addr_t'({qwords_to_rd, 3'b000});
                        state <= ST_SIZE;
                    end
                end

                ST_DONE: begin
                    if (!huge_page_status) begin            // host takes the region back
                        state <= ST_IDLE;
                    end
                end

                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* rtl/tx_dma_pkg.sv */
`default_nettype none

package tx_dma_pkg;

    //////////////////////////////
    // ring buffer
    //////////////////////////////
    localparam int BUF_AW = 9;                          // 512 qwords

    typedef logic [BUF_AW-1:0] buf_addr_t;
    typedef logic [BUF_AW:0]   buf_ptr_t;               // msb is the wrap bit
    typedef logic [63:0]       qword_t;

    //////////////////////////////
    // tags and requests
    //////////////////////////////
    localparam int N_TAGS = 4;                          // max outstanding reads

    typedef logic [1:0]  tag_t;
    typedef logic [8:0]  rd_size_t;                     // qwords, up to 128
    typedef logic [63:0] host_addr_t;
    typedef logic [31:0] region_len_t;

    // max read request size in qwords
    localparam rd_size_t MAX_QW_128B = 9'd16;
    localparam rd_size_t MAX_QW_256B = 9'd32;
    localparam rd_size_t MAX_QW_512B = 9'd64;
    localparam rd_size_t MAX_QW_1KB  = 9'd128;

    //////////////////////////////
    // completion header fields
    //////////////////////////////
    localparam logic [6:0] CPL_FMT_TYPE  = 7'h4A;       // CplD
    localparam logic [2:0] CPL_STATUS_SC = 3'd0;        // successful completion

endpackage

`default_nettype wire
